// File: files.f
+incdir+include
+incdir+testbench
rtl/loader_pkg.sv
rtl/mem_slot_scheduler.sv
rtl/crt_chip_parser.sv
rtl/cart_info_regs.sv
rtl/memory_eraser.sv
rtl/tape_player.sv
rtl/c64_loader.sv
testbench/tb_c64_loader.sv

// File: include/loader_settings.svh
/*
 * Loader constants
 *  RAM bases for cartridge and tape images
 *  Host download indexes and cartridge header offsets
 *  Erase pacing and limits, tape rewind margin
 */
`ifndef LOADER_SETTINGS_SVH
`define LOADER_SETTINGS_SVH

// RAM regions for stored images
`define LDR_CRT_BASE        25'h100000
`define LDR_TAP_BASE        25'h200000

// Host download indexes
`define LDR_PRG_INDEX       8'd2
`define LDR_CRT_INDEX       8'd3
`define LDR_CRT_INDEX_ALT   8'hC0
`define LDR_TAP_INDEX       8'd4

// Cartridge image layout
`define LDR_CRT_ID_OFS      25'h16
`define LDR_CRT_CHIP_OFS    25'h40

// 2**bits idle cycles between fill writes
`define LDR_ERASE_GAP_BITS  5
`define LDR_ERASE_TOP       25'h0FFFF
`define LDR_ERASE_TOP_CART  25'h1FFFF

// Rewind when fewer bytes remain with the motor on
`define LDR_TAP_MARGIN      25'd80

`endif

// File: rtl/c64_loader.sv
/*
 * Memory loader core
 *  Slot scheduler, cartridge parser and header registers
 *  Memory eraser and tape player
 */
`timescale 1ns/100ps

module c64_loader (
	input  logic                     clk_sys,
	input  logic                     reset_n,
	input  logic                     ioctl_download_i,
	input  loader_pkg::data_t        ioctl_index_i,
	input  loader_pkg::mem_addr_t    ioctl_addr_i,
	input  loader_pkg::data_t        ioctl_data_i,
	input  logic                     ioctl_wr_i,
	output logic                     ioctl_wait_o,
	input  logic                     slot_i,
	output logic                     mem_ce_o,
	output logic                     mem_we_o,
	output loader_pkg::mem_addr_t    mem_addr_o,
	output loader_pkg::data_t        mem_din_o,
	input  logic                     erase_i,
	input  logic                     detach_i,
	input  logic                     tape_play_btn_i,
	input  logic                     tape_unload_i,
	input  logic                     cass_motor_i,
	input  logic                     tape_fifo_full_i,
	input  logic                     tape_fifo_empty_i,
	output logic                     tape_wr_o,
	output logic                     tape_play_o,
	output logic                     erasing_o,
	output loader_pkg::cart_word_t   cart_id_o,
	output loader_pkg::data_t        cart_exrom_o,
	output loader_pkg::data_t        cart_game_o,
	output loader_pkg::data_t        cart_bank_type_o,
	output loader_pkg::cart_word_t   cart_bank_num_o,
	output loader_pkg::cart_word_t   cart_bank_laddr_o,
	output loader_pkg::cart_word_t   cart_bank_size_o,
	output logic                     cart_bank_wr_o,
	output logic                     cart_attached_o
);

	loader_pkg::dl_kind_t   dl_kind;
	loader_pkg::crt_field_t hdr_field;
	loader_pkg::mem_addr_t  load_addr;
	loader_pkg::mem_addr_t  tape_addr;
	logic crt_base;
	logic crt_align;
	logic crt_data_wr;
	logic hdr_field_wr;
	logic erase_start;
	logic erase_wr;
	logic write_pending;
	logic tape_slot_read;

	mem_slot_scheduler mem_slot_scheduler_inst (
		.clk_sys, .reset_n,
		.ioctl_wr_i, .ioctl_index_i, .ioctl_addr_i, .ioctl_data_i,
		.slot_i,
		.crt_base_i(crt_base), .crt_align_i(crt_align), .crt_data_wr_i(crt_data_wr),
		.erase_start_i(erase_start), .erase_wr_i(erase_wr), .erasing_i(erasing_o),
		.tape_addr_i(tape_addr),
		.dl_kind_o(dl_kind),
		.ioctl_wait_o,
		.mem_ce_o, .mem_we_o, .mem_addr_o, .mem_din_o,
		.write_pending_o(write_pending),
		.load_addr_o(load_addr),
		.tape_slot_read_o(tape_slot_read)
	);

	crt_chip_parser crt_chip_parser_inst (
		.clk_sys, .reset_n,
		.ioctl_wr_i, .ioctl_addr_i, .ioctl_data_i,
		.dl_kind_i(dl_kind),
		.crt_base_o(crt_base), .crt_align_o(crt_align), .crt_data_wr_o(crt_data_wr),
		.hdr_field_o(hdr_field), .hdr_field_wr_o(hdr_field_wr),
		.cart_bank_wr_o
	);

	cart_info_regs cart_info_regs_inst (
		.clk_sys, .reset_n,
		.ioctl_data_i, .ioctl_download_i,
		.dl_kind_i(dl_kind),
		.hdr_field_i(hdr_field), .hdr_field_wr_i(hdr_field_wr),
		.detach_i,
		.cart_id_o, .cart_exrom_o, .cart_game_o, .cart_bank_type_o,
		.cart_bank_num_o, .cart_bank_laddr_o, .cart_bank_size_o,
		.cart_attached_o
	);

	memory_eraser memory_eraser_inst (
		.clk_sys, .reset_n,
		.erase_i,
		.cart_attached_i(cart_attached_o),
		.write_pending_i(write_pending),
		.load_addr_i(load_addr),
		.erase_start_o(erase_start), .erase_wr_o(erase_wr), .erasing_o
	);

	tape_player tape_player_inst (
		.clk_sys, .reset_n,
		.ioctl_download_i, .ioctl_addr_i,
		.dl_kind_i(dl_kind),
		.tape_play_btn_i, .tape_unload_i, .cass_motor_i,
		.tape_fifo_full_i, .tape_fifo_empty_i,
		.tape_slot_read_i(tape_slot_read),
		.tape_addr_o(tape_addr), .tape_wr_o, .tape_play_o
	);

endmodule

// File: rtl/cart_info_regs.sv
/*
 * Cartridge header registers
 *  Global and bank header fields
 *  Attach flag
 */
`timescale 1ns/100ps

module cart_info_regs (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	input  loader_pkg::data_t      ioctl_data_i,
	input  logic                   ioctl_download_i,
	input  loader_pkg::dl_kind_t   dl_kind_i,
	input  loader_pkg::crt_field_t hdr_field_i,
	input  logic                   hdr_field_wr_i,
	input  logic                   detach_i,
	output loader_pkg::cart_word_t cart_id_o,
	output loader_pkg::data_t      cart_exrom_o,
	output loader_pkg::data_t      cart_game_o,
	output loader_pkg::data_t      cart_bank_type_o,
	output loader_pkg::cart_word_t cart_bank_num_o,
	output loader_pkg::cart_word_t cart_bank_laddr_o,
	output loader_pkg::cart_word_t cart_bank_size_o,
	output logic                   cart_attached_o
);

	logic download_d;
	logic detach_d;

	always_ff @(posedge clk_sys) begin
		if (hdr_field_wr_i) begin
			case (hdr_field_i)
				loader_pkg::F_ID_HI:    cart_id_o[15:8]         <= ioctl_data_i;
				loader_pkg::F_ID_LO:    cart_id_o[7:0]          <= ioctl_data_i;
				loader_pkg::F_EXROM:    cart_exrom_o            <= ioctl_data_i;
				loader_pkg::F_GAME:     cart_game_o             <= ioctl_data_i;
				loader_pkg::F_TYPE:     cart_bank_type_o        <= ioctl_data_i;
				loader_pkg::F_BANK_HI:  cart_bank_num_o[15:8]   <= ioctl_data_i;
				loader_pkg::F_BANK_LO:  cart_bank_num_o[7:0]    <= ioctl_data_i;
				loader_pkg::F_LADDR_HI: cart_bank_laddr_o[15:8] <= ioctl_data_i;
				loader_pkg::F_LADDR_LO: cart_bank_laddr_o[7:0]  <= ioctl_data_i;
				loader_pkg::F_SIZE_HI:  cart_bank_size_o[15:8]  <= ioctl_data_i;
				loader_pkg::F_SIZE_LO:  cart_bank_size_o[7:0]   <= ioctl_data_i;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			download_d      <= 1'b0;
			detach_d        <= 1'b0;
			cart_attached_o <= 1'b0;
		end else begin
			download_d <= ioctl_download_i;
			detach_d   <= detach_i;
			// Cleared while a new image streams in, set once it has ended
			if (download_d != ioctl_download_i && dl_kind_i == loader_pkg::DL_CRT)
				cart_attached_o <= download_d;
			if (detach_i && !detach_d)
				cart_attached_o <= 1'b0;
		end
	end

endmodule

// File: rtl/crt_chip_parser.sv
/*
 * Cartridge image parser
 *  Global header field strobes
 *  Chip packet header count and remaining block length
 *  Base, alignment and data write commands for the scheduler
 */
`timescale 1ns/100ps
`include "loader_settings.svh"

module crt_chip_parser (
	input  logic                    clk_sys,
	input  logic                    reset_n,
	input  logic                    ioctl_wr_i,
	input  loader_pkg::mem_addr_t   ioctl_addr_i,
	input  loader_pkg::data_t       ioctl_data_i,
	input  loader_pkg::dl_kind_t    dl_kind_i,
	output logic                    crt_base_o,
	output logic                    crt_align_o,
	output logic                    crt_data_wr_o,
	output loader_pkg::crt_field_t  hdr_field_o,
	output logic                    hdr_field_wr_o,
	output logic                    cart_bank_wr_o
);

	loader_pkg::blk_len_t   blk_len;
	loader_pkg::crt_field_t field_sel;
	logic [3:0] hdr_cnt;
	logic crt_byte;
	logic chip_area;
	logic hdr_start;
	logic field_hit;

	assign crt_byte  = ioctl_wr_i & (dl_kind_i == loader_pkg::DL_CRT);
	assign chip_area = ioctl_addr_i >= `LDR_CRT_CHIP_OFS;
	// No block left and no header in progress, so a new chip packet begins
	assign hdr_start = chip_area & (blk_len == '0) & (hdr_cnt == 4'd0);

	assign crt_base_o    = crt_byte & (ioctl_addr_i == '0);
	assign crt_align_o   = crt_byte & hdr_start;
	assign crt_data_wr_o = crt_byte & chip_area & ~hdr_start & (hdr_cnt == 4'd0);

	always_comb begin
		field_hit = 1'b1;
		field_sel = loader_pkg::F_ID_HI;
		if (!chip_area) begin
			case (ioctl_addr_i)
				`LDR_CRT_ID_OFS:          field_sel = loader_pkg::F_ID_HI;
				`LDR_CRT_ID_OFS + 25'd1:  field_sel = loader_pkg::F_ID_LO;
				`LDR_CRT_ID_OFS + 25'd2:  field_sel = loader_pkg::F_EXROM;
				`LDR_CRT_ID_OFS + 25'd3:  field_sel = loader_pkg::F_GAME;
				default:                  field_hit = 1'b0;
			endcase
		end else begin
			// Chip header bytes 9 to 15
			case (hdr_cnt)
				4'd9:    field_sel = loader_pkg::F_TYPE;
				4'd10:   field_sel = loader_pkg::F_BANK_HI;
				4'd11:   field_sel = loader_pkg::F_BANK_LO;
				4'd12:   field_sel = loader_pkg::F_LADDR_HI;
				4'd13:   field_sel = loader_pkg::F_LADDR_LO;
				4'd14:   field_sel = loader_pkg::F_SIZE_HI;
				4'd15:   field_sel = loader_pkg::F_SIZE_LO;
				default: field_hit = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			hdr_cnt        <= 4'd0;
			blk_len        <= '0;
			hdr_field_wr_o <= 1'b0;
			cart_bank_wr_o <= 1'b0;
		end else begin
			hdr_field_wr_o <= crt_byte & field_hit;
			cart_bank_wr_o <= crt_byte & chip_area & (hdr_cnt == 4'd15);
			if (crt_byte) begin
				if (crt_base_o) begin
					hdr_cnt <= 4'd0;
					blk_len <= '0;
				end else if (hdr_start) begin
					hdr_cnt <= 4'd1;
				end else if (hdr_cnt != 4'd0) begin
					// Wraps to zero after the 16th header byte
					hdr_cnt <= hdr_cnt + 1'b1;
					case (hdr_cnt)
						4'd4, 4'd5, 4'd6, 4'd7: blk_len <= {blk_len[23:0], ioctl_data_i};
						4'd8:                   blk_len <= blk_len - 32'd16;
						default: ;
					endcase
				end else if (chip_area) begin
					blk_len <= blk_len - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (crt_byte && field_hit)
			hdr_field_o <= field_sel;
	end

endmodule

// File: rtl/loader_pkg.sv
/*
 * Loader package
 *  Vector types for addresses, bytes and cartridge fields
 *  Download kind and cartridge header field enums
 */
package loader_pkg;

	typedef logic [24:0] mem_addr_t;
	typedef logic [7:0]  data_t;
	typedef logic [15:0] cart_word_t;
	typedef logic [31:0] blk_len_t;

	typedef enum logic [1:0] {
		DL_NONE,
		DL_PRG,
		DL_CRT,
		DL_TAP
	} dl_kind_t;

	// Header bytes latched by the cartridge register block
	typedef enum logic [3:0] {
		F_ID_HI,
		F_ID_LO,
		F_EXROM,
		F_GAME,
		F_TYPE,
		F_BANK_HI,
		F_BANK_LO,
		F_LADDR_HI,
		F_LADDR_LO,
		F_SIZE_HI,
		F_SIZE_LO
	} crt_field_t;

endpackage

// File: rtl/mem_slot_scheduler.sv
/*
 * Memory slot scheduler
 *  Download kind decode and the RAM load address
 *  One pending write, issued at the end of a slot
 *  Tape reads in slots that carry no write
 */
`timescale 1ns/100ps
`include "loader_settings.svh"

module mem_slot_scheduler (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  logic                  ioctl_wr_i,
	input  loader_pkg::data_t     ioctl_index_i,
	input  loader_pkg::mem_addr_t ioctl_addr_i,
	input  loader_pkg::data_t     ioctl_data_i,
	input  logic                  slot_i,
	input  logic                  crt_base_i,
	input  logic                  crt_align_i,
	input  logic                  crt_data_wr_i,
	input  logic                  erase_start_i,
	input  logic                  erase_wr_i,
	input  logic                  erasing_i,
	input  loader_pkg::mem_addr_t tape_addr_i,
	output loader_pkg::dl_kind_t  dl_kind_o,
	output logic                  ioctl_wait_o,
	output logic                  mem_ce_o,
	output logic                  mem_we_o,
	output loader_pkg::mem_addr_t mem_addr_o,
	output loader_pkg::data_t     mem_din_o,
	output logic                  write_pending_o,
	output loader_pkg::mem_addr_t load_addr_o,
	output logic                  tape_slot_read_o
);

	loader_pkg::mem_addr_t load_addr;
	loader_pkg::data_t     wr_data;
	logic slot_d;
	logic slot_fall;
	logic slot_second;
	logic req_wr;
	logic rd_served;

	always_comb begin
		case (ioctl_index_i)
			`LDR_PRG_INDEX:                     dl_kind_o = loader_pkg::DL_PRG;
			`LDR_CRT_INDEX, `LDR_CRT_INDEX_ALT: dl_kind_o = loader_pkg::DL_CRT;
			`LDR_TAP_INDEX:                     dl_kind_o = loader_pkg::DL_TAP;
			default:                            dl_kind_o = loader_pkg::DL_NONE;
		endcase
	end

	assign slot_fall        = ~slot_i & slot_d;
	assign slot_second      = slot_i & slot_d;
	assign ioctl_wait_o     = req_wr;
	assign write_pending_o  = req_wr;
	assign load_addr_o      = load_addr;
	assign tape_slot_read_o = slot_second & rd_served;

	// ======================================================================
	// Slot issue and load address
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			slot_d    <= 1'b0;
			req_wr    <= 1'b0;
			rd_served <= 1'b0;
			mem_ce_o  <= 1'b0;
			mem_we_o  <= 1'b0;
			load_addr <= '0;
		end else begin
			slot_d <= slot_i;

			// Memory has sampled the request by now
			if (slot_second) begin
				mem_ce_o  <= 1'b0;
				mem_we_o  <= 1'b0;
				rd_served <= 1'b0;
			end

			// Pending write wins, otherwise the slot reads tape data
			if (slot_fall) begin
				mem_ce_o  <= 1'b1;
				mem_we_o  <= req_wr;
				rd_served <= ~req_wr;
				if (req_wr) begin
					req_wr    <= 1'b0;
					load_addr <= load_addr + 1'b1;
				end
			end

			if (ioctl_wr_i) begin
				case (dl_kind_o)
					loader_pkg::DL_PRG: begin
						// First two bytes carry the load address, low byte first
						if (ioctl_addr_i == 25'd0)
							load_addr <= loader_pkg::mem_addr_t'(ioctl_data_i);
						else if (ioctl_addr_i == 25'd1)
							load_addr[15:8] <= ioctl_data_i;
						else
							req_wr <= 1'b1;
					end
					loader_pkg::DL_TAP: begin
						if (ioctl_addr_i == 25'd0)
							load_addr <= `LDR_TAP_BASE;
						req_wr <= 1'b1;
					end
					default: ;
				endcase
			end

			if (crt_base_i)
				load_addr <= `LDR_CRT_BASE;
			// Chip data starts on the next 8 KB boundary
			if (crt_align_i && load_addr[12:0] != 13'd0)
				load_addr <= {load_addr[24:13] + 1'b1, 13'd0};
			if (crt_data_wr_i)
				req_wr <= 1'b1;

			if (erase_start_i)
				load_addr <= '0;
			if (erase_wr_i)
				req_wr <= 1'b1;
		end
	end

	// Write payload and request address
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr_i)
			wr_data <= ioctl_data_i;
		if (slot_fall) begin
			if (req_wr) begin
				mem_addr_o <= load_addr;
				// Fill pattern alternates every 64 bytes
				mem_din_o  <= erasing_i ? {8{load_addr[6]}} : wr_data;
			end else begin
				mem_addr_o <= `LDR_TAP_BASE + tape_addr_i;
			end
		end
	end

	// A write strobe always rides on an active request
	assert property (@(posedge clk_sys) disable iff (!reset_n)
		$rose(mem_we_o) |-> mem_ce_o);

endmodule

// File: rtl/memory_eraser.sv
/*
 * RAM eraser
 *  Paced fill writes from address zero up to the chosen top
 */
`timescale 1ns/100ps
`include "loader_settings.svh"

module memory_eraser (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  logic                  erase_i,
	input  logic                  cart_attached_i,
	input  logic                  write_pending_i,
	input  loader_pkg::mem_addr_t load_addr_i,
	output logic                  erase_start_o,
	output logic                  erase_wr_o,
	output logic                  erasing_o
);

	logic [`LDR_ERASE_GAP_BITS-1:0] gap_cnt;
	loader_pkg::mem_addr_t erase_top;
	logic gap_run;

	// Count only while no write is queued or in flight
	assign gap_run = erasing_o & ~write_pending_i & ~erase_wr_o & ~erase_start_o;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			erase_start_o <= 1'b0;
			erase_wr_o    <= 1'b0;
			erasing_o     <= 1'b0;
			gap_cnt       <= '0;
			erase_top     <= `LDR_ERASE_TOP;
		end else begin
			erase_start_o <= 1'b0;
			erase_wr_o    <= 1'b0;
			if (erase_i && !erasing_o) begin
				erasing_o     <= 1'b1;
				erase_start_o <= 1'b1;
				gap_cnt       <= '0;
				// Cartridge RAM above 64 KB is cleared too
				erase_top     <= cart_attached_i ? `LDR_ERASE_TOP_CART : `LDR_ERASE_TOP;
			end else if (gap_run) begin
				gap_cnt <= gap_cnt + 1'b1;
				if (&gap_cnt) begin
					if (load_addr_i <= erase_top)
						erase_wr_o <= 1'b1;
					else
						erasing_o <= 1'b0;
				end
			end
		end
	end

	// Each fill write is queued in the scheduler on the next cycle
	assert property (@(posedge clk_sys) disable iff (!reset_n)
		erase_wr_o |-> erasing_o ##1 write_pending_i);

endmodule

// File: rtl/tape_player.sv
/*
 * Tape player
 *  Play state, restart and end address
 *  Fetch address and FIFO write strobes
 */
`timescale 1ns/100ps
`include "loader_settings.svh"

module tape_player (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  logic                  ioctl_download_i,
	input  loader_pkg::mem_addr_t ioctl_addr_i,
	input  loader_pkg::dl_kind_t  dl_kind_i,
	input  logic                  tape_play_btn_i,
	input  logic                  tape_unload_i,
	input  logic                  cass_motor_i,
	input  logic                  tape_fifo_full_i,
	input  logic                  tape_fifo_empty_i,
	input  logic                  tape_slot_read_i,
	output loader_pkg::mem_addr_t tape_addr_o,
	output logic                  tape_wr_o,
	output logic                  tape_play_o
);

	loader_pkg::mem_addr_t last_addr;
	logic restart;
	logic loaded;
	logic fetch_pend;
	logic btn_d;
	logic empty_d;

	assign loaded  = tape_addr_o < last_addr;
	assign restart = (ioctl_download_i & (dl_kind_i == loader_pkg::DL_TAP)) | tape_unload_i |
		(cass_motor_i & ((last_addr - tape_addr_o) < `LDR_TAP_MARGIN));

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			last_addr   <= '0;
			tape_addr_o <= '0;
			tape_wr_o   <= 1'b0;
			tape_play_o <= 1'b0;
			fetch_pend  <= 1'b0;
			btn_d       <= 1'b0;
			empty_d     <= 1'b0;
		end else begin
			btn_d     <= tape_play_btn_i;
			empty_d   <= tape_fifo_empty_i;
			tape_wr_o <= 1'b0;
			if (restart) begin
				// Two bytes past the last address so the FIFO never runs dry early
				last_addr   <= ioctl_download_i ? ioctl_addr_i + 25'd2 : '0;
				tape_addr_o <= '0;
				tape_play_o <= ioctl_download_i;
				fetch_pend  <= 1'b0;
			end else begin
				if (tape_play_btn_i && !btn_d)
					tape_play_o <= ~tape_play_o;
				if (tape_fifo_empty_i && !empty_d)
					tape_play_o <= 1'b0;
				if (fetch_pend && tape_slot_read_i) begin
					tape_addr_o <= tape_addr_o + 1'b1;
					fetch_pend  <= 1'b0;
					tape_wr_o   <= 1'b1;
				end else if (!fetch_pend && !tape_wr_o && !tape_fifo_full_i && loaded) begin
					// Full flag settles one cycle after a write
					fetch_pend <= 1'b1;
				end
			end
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# Build the loader testbench with Verilator and run it from the project root
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f files.f --top-module tb_c64_loader -o sim_c64_loader

./obj_dir/sim_c64_loader > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
	exit 1
fi
grep -q "NO ERRORS" sim.log

// File: testbench/tb_loader_tests.svh
/*
 * Directed loader tests
 *  Helpers for cycles, checks, random bytes and host writes
 *  Reset, program, cartridge, tape and erase tests
 */
`ifndef TB_LOADER_TESTS_SVH
`define TB_LOADER_TESTS_SVH

task automatic wait_cycles(input int n);
	repeat (n) @(negedge clk_sys);
endtask

function automatic logic [7:0] lcg_next();
	rand_state = rand_state * 32'd1103515245 + 32'd12345;
	return rand_state[23:16];
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	assert (got === exp) else begin
		$display("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp);
		error_count++;
	end
endtask

function automatic logic [7:0] mem_byte(input logic [24:0] addr);
	return mem.exists(addr) ? mem[addr] : 8'hxx;
endfunction

// Host strobe held off while the core asks to wait
// The byte stays on the data lines for one idle cycle after the strobe
task automatic send_byte(input logic [24:0] addr, input logic [7:0] data);
	int guard;
	guard = 0;
	while (ioctl_wait_o && guard < 4 * SLOT_CYCLES) begin
		@(negedge clk_sys);
		guard++;
	end
	assert (!ioctl_wait_o) else begin
		$display("Host wait stayed high too long before byte at 0x%0h", addr);
		error_count++;
	end
	ioctl_addr_i = addr;
	ioctl_data_i = data;
	ioctl_wr_i = 1'b1;
	@(negedge clk_sys);
	ioctl_wr_i = 1'b0;
	@(negedge clk_sys);
endtask

task automatic drain_writes();
	int guard;
	guard = 0;
	while (ioctl_wait_o && guard < 4 * SLOT_CYCLES) begin
		@(negedge clk_sys);
		guard++;
	end
	assert (!ioctl_wait_o) else begin
		$display("Last queued write was never issued");
		error_count++;
	end
	wait_cycles(2 * SLOT_CYCLES);
endtask

// ======================================================================
// Tests
// ======================================================================
task automatic check_reset_outputs();
	check_value("ioctl_wait_o", ioctl_wait_o, 0);
	check_value("mem_ce_o", mem_ce_o, 0);
	check_value("mem_we_o", mem_we_o, 0);
	check_value("tape_wr_o", tape_wr_o, 0);
	check_value("cart_bank_wr_o", cart_bank_wr_o, 0);
	check_value("erasing_o", erasing_o, 0);
	check_value("tape_play_o", tape_play_o, 0);
	check_value("cart_attached_o", cart_attached_o, 0);
endtask

task automatic load_program();
	logic [7:0] bytes [40];
	logic [24:0] base;
	base = 25'h0801;
	ioctl_index_i = `LDR_PRG_INDEX;
	ioctl_download_i = 1'b1;
	wait_cycles(1);
	send_byte(25'd0, base[7:0]);
	send_byte(25'd1, base[15:8]);
	for (int i = 0; i < 40; i++) begin
		bytes[i] = lcg_next();
		send_byte(25'(i + 2), bytes[i]);
	end
	drain_writes();
	ioctl_download_i = 1'b0;
	wait_cycles(2);
	for (int i = 0; i < 40; i++)
		check_value($sformatf("mem[0x%0h]", base + i), mem_byte(base + 25'(i)), bytes[i]);
endtask

task automatic load_cartridge();
	logic [7:0] image [144];
	for (int i = 0; i < 144; i++)
		image[i] = 8'h00;
	image[8'h16] = 8'h00;
	image[8'h17] = 8'h13;
	image[8'h18] = 8'h01;
	image[8'h19] = 8'h00;
	// Chip packet with CHIP tag, length 0x50, type, bank, load address and size
	image[8'h40] = 8'h43;
	image[8'h41] = 8'h48;
	image[8'h42] = 8'h49;
	image[8'h43] = 8'h50;
	image[8'h47] = 8'h50;
	image[8'h49] = 8'h02;
	image[8'h4B] = 8'h05;
	image[8'h4C] = 8'h80;
	image[8'h4F] = 8'h40;
	for (int i = 0; i < 64; i++)
		image[80 + i] = lcg_next();
	bank_wr_count = 0;
	ioctl_index_i = `LDR_CRT_INDEX;
	ioctl_download_i = 1'b1;
	wait_cycles(1);
	for (int i = 0; i < 144; i++)
		send_byte(25'(i), image[i]);
	drain_writes();
	check_value("cart_id_o", cart_id_o, 32'h0013);
	check_value("cart_exrom_o", cart_exrom_o, 32'h01);
	check_value("cart_game_o", cart_game_o, 32'h00);
	check_value("cart_bank_type_o", cart_bank_type_o, 32'h02);
	check_value("cart_bank_num_o", cart_bank_num_o, 32'h0005);
	check_value("cart_bank_laddr_o", cart_bank_laddr_o, 32'h8000);
	check_value("cart_bank_size_o", cart_bank_size_o, 32'h0040);
	check_value("cart_bank_wr_o pulses", bank_wr_count, 1);
	ioctl_download_i = 1'b0;
	wait_cycles(3);
	check_value("cart_attached_o", cart_attached_o, 1);
	for (int i = 0; i < 64; i++)
		check_value($sformatf("mem[0x%0h]", `LDR_CRT_BASE + i),
			mem_byte(`LDR_CRT_BASE + 25'(i)), image[80 + i]);
	detach_i = 1'b1;
	wait_cycles(1);
	detach_i = 1'b0;
	wait_cycles(2);
	check_value("cart_attached_o", cart_attached_o, 0);
endtask

task automatic play_tape();
	logic [7:0] bytes [30];
	int guard;
	tape_fifo_full_i = 1'b1;
	ioctl_index_i = `LDR_TAP_INDEX;
	ioctl_download_i = 1'b1;
	wait_cycles(1);
	for (int i = 0; i < 30; i++) begin
		bytes[i] = lcg_next();
		send_byte(25'(i), bytes[i]);
	end
	drain_writes();
	ioctl_download_i = 1'b0;
	wait_cycles(2);
	tape_bytes.delete();
	wait_cycles(6 * SLOT_CYCLES);
	check_value("tape_wr_o pulses while full", tape_bytes.size(), 0);
	check_value("tape_play_o", tape_play_o, 1);
	for (int i = 0; i < 30; i++)
		check_value($sformatf("mem[0x%0h]", `LDR_TAP_BASE + i),
			mem_byte(`LDR_TAP_BASE + 25'(i)), bytes[i]);
	tape_fifo_full_i = 1'b0;
	guard = 0;
	while (tape_bytes.size() < 30 && guard < 30 * 4 * SLOT_CYCLES) begin
		@(negedge clk_sys);
		guard++;
	end
	assert (tape_bytes.size() >= 30) else begin
		$display("Tape playback delivered only %0d bytes", tape_bytes.size());
		error_count++;
	end
	for (int i = 0; i < 30 && i < tape_bytes.size(); i++)
		check_value($sformatf("tape byte %0d", i), tape_bytes[i], bytes[i]);
	tape_fifo_empty_i = 1'b1;
	wait_cycles(3);
	check_value("tape_play_o", tape_play_o, 0);
	tape_fifo_empty_i = 1'b0;
endtask

task automatic erase_memory();
	longint guard;
	logic [24:0] addr;
	// Empty cartridge download attaches it again
	ioctl_index_i = `LDR_CRT_INDEX;
	ioctl_download_i = 1'b1;
	wait_cycles(2);
	ioctl_download_i = 1'b0;
	wait_cycles(3);
	check_value("cart_attached_o", cart_attached_o, 1);
	ioctl_index_i = 8'h00;
	erase_i = 1'b1;
	wait_cycles(1);
	erase_i = 1'b0;
	wait_cycles(1);
	check_value("erasing_o", erasing_o, 1);
	guard = 0;
	while (erasing_o && guard < 2 * ERASE_WRITES * WRITE_CYCLES) begin
		@(negedge clk_sys);
		guard++;
	end
	assert (!erasing_o) else begin
		$display("Erase did not finish in time");
		error_count++;
	end
	wait_cycles(2 * SLOT_CYCLES);
	for (int a = 0; a <= 32'h1FFFF; a += 97) begin
		addr = 25'(a);
		check_value($sformatf("mem[0x%0h]", addr), mem_byte(addr), addr[6] ? 8'hFF : 8'h00);
	end
	check_value("mem[0x1ffff]", mem_byte(25'h1FFFF), 8'hFF);
endtask

`endif

// File: testbench/tb_c64_loader.sv
/*
 * Loader core testbench
 *  Clock, reset, slot generator and sparse memory model
 *  Output monitors, watchdog and the closing summary
 *  Directed tests come from the included task file
 */
`timescale 1ns/100ps
`include "loader_settings.svh"

module tb_c64_loader;

	localparam int CLK_PERIOD   = 8;
	localparam int SLOT_CYCLES  = 8;
	localparam int ERASE_WRITES = 32'h20000;
	localparam int STREAM_BYTES = 2 + 40 + 32'h40 + 80 + 30;
	// Worst case for one paced write is the gap plus a few slots
	localparam int WRITE_CYCLES = (1 << `LDR_ERASE_GAP_BITS) + 3 * SLOT_CYCLES;
	localparam longint WATCHDOG_CYCLES = 2 * (ERASE_WRITES + STREAM_BYTES) * WRITE_CYCLES + 5000;

	logic clk_sys;
	logic reset_n;
	logic ioctl_download_i;
	loader_pkg::data_t ioctl_index_i;
	loader_pkg::mem_addr_t ioctl_addr_i;
	loader_pkg::data_t ioctl_data_i;
	logic ioctl_wr_i;
	logic ioctl_wait_o;
	logic slot_i;
	logic mem_ce_o;
	logic mem_we_o;
	loader_pkg::mem_addr_t mem_addr_o;
	loader_pkg::data_t mem_din_o;
	loader_pkg::data_t mem_dout_i;
	logic erase_i;
	logic detach_i;
	logic tape_play_btn_i;
	logic tape_unload_i;
	logic cass_motor_i;
	logic tape_fifo_full_i;
	logic tape_fifo_empty_i;
	logic tape_wr_o;
	logic tape_play_o;
	logic erasing_o;
	loader_pkg::cart_word_t cart_id_o;
	loader_pkg::data_t cart_exrom_o;
	loader_pkg::data_t cart_game_o;
	loader_pkg::data_t cart_bank_type_o;
	loader_pkg::cart_word_t cart_bank_num_o;
	loader_pkg::cart_word_t cart_bank_laddr_o;
	loader_pkg::cart_word_t cart_bank_size_o;
	logic cart_bank_wr_o;
	logic cart_attached_o;

	logic [7:0] mem [logic [24:0]];
	logic [7:0] tape_bytes [$];
	logic [31:0] rand_state;
	int error_count;
	int bank_wr_count;
	int slot_cnt;
	logic slot_q;

	c64_loader c64_loader_inst (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// Slot is 3 cycles high and 5 low
	always @(negedge clk_sys) begin
		slot_cnt <= (slot_cnt == SLOT_CYCLES - 1) ? 0 : slot_cnt + 1;
		slot_i   <= (slot_cnt < 3);
	end

	// Memory takes the request on the first cycle of a slot
	always @(posedge clk_sys) begin
		if (slot_i && !slot_q && mem_ce_o) begin
			if (mem_we_o)
				mem[mem_addr_o] = mem_din_o;
			else
				mem_dout_i <= mem.exists(mem_addr_o) ? mem[mem_addr_o] : 8'h00;
		end
		slot_q <= slot_i;
	end

	always @(negedge clk_sys) begin
		if (cart_bank_wr_o)
			bank_wr_count++;
		if (tape_wr_o)
			tape_bytes.push_back(mem_dout_i);
	end

	`include "tb_loader_tests.svh"

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the tests finished");
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		rand_state = 32'h115;
		error_count = 0;
		bank_wr_count = 0;
		slot_cnt = 0;
		slot_i = 1'b0;
		slot_q = 1'b0;
		mem_dout_i = 8'h00;
		reset_n = 1'b0;
		ioctl_download_i = 1'b0;
		ioctl_index_i = 8'h00;
		ioctl_addr_i = '0;
		ioctl_data_i = 8'h00;
		ioctl_wr_i = 1'b0;
		erase_i = 1'b0;
		detach_i = 1'b0;
		tape_play_btn_i = 1'b0;
		tape_unload_i = 1'b0;
		cass_motor_i = 1'b0;
		tape_fifo_full_i = 1'b0;
		tape_fifo_empty_i = 1'b0;
		wait_cycles(3);
		reset_n = 1'b1;
		wait_cycles(1);

		check_reset_outputs();
		load_program();
		load_cartridge();
		play_tape();
		erase_memory();

		$display("Tests finished with %0d errors", error_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule
